// ==== design/fadd_defs.svh ====
`ifndef FADD_DEFS_SVH
`define FADD_DEFS_SVH

// binary64 field widths
`define FP_W        64
`define EXP_W       11
`define FRAC_W      52

// working mantissa is hidden one + fraction + guard/round/sticky
// the adder widens it by one carry bit
`define MANT_W      56

// exponent limits
`define EXP_MAX     11'h7FF
`define MAXFIN_EXP  11'h7FE

// canonical quiet NaN
`define QNAN        64'h7FF8_0000_0000_0000

// cycles from en to res_valid
`define FADD_LAT    2

`endif

// ==== design/fadd_pkg.sv ====
package fadd_pkg;

  // rounding modes as seen on the rmode pins
  typedef enum logic [1:0] {
    RND_ZERO  = 2'd0,
    RND_EVEN  = 2'd1,
    RND_PLUS  = 2'd2,
    RND_MINUS = 2'd3
  } rmode_e;

  // arithmetic and raw-bit logic opcodes
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_ANDN = 3'd5
  } op_e;

endpackage

// ==== design/fadd_if.sv ====
`timescale 1ns/1ps
`include "fadd_defs.svh"

// stage-1 arithmetic bundle, align to round
interface align_if;
  import fadd_pkg::*;

  logic               s1_valid;
  logic               s1_sign;
  logic [`EXP_W-1:0]  s1_exp;
  logic [`MANT_W-1:0] s1_big;
  logic [`MANT_W-1:0] s1_small;
  logic               s1_sub;
  rmode_e             s1_rmode;

  modport src (
    output s1_valid, s1_sign, s1_exp, s1_big, s1_small, s1_sub, s1_rmode
  );

  modport dst (
    input s1_valid, s1_sign, s1_exp, s1_big, s1_small, s1_sub, s1_rmode
  );
endinterface

// stage-1 special and logic result, bypass to round
interface bypass_if;
  logic             byp_hit;
  logic [`FP_W-1:0] byp_value;
  logic             byp_invalid;
  logic             byp_zero_sum;

  modport src (
    output byp_hit, byp_value, byp_invalid, byp_zero_sum
  );

  modport dst (
    input byp_hit, byp_value, byp_invalid, byp_zero_sum
  );
endinterface

// ==== design/fadd_bypass.sv ====
`timescale 1ns/1ps
`include "fadd_defs.svh"

module fadd_bypass (
  input  logic             clk,
  input  logic             rst,
  input  logic             en,
  input  fadd_pkg::op_e    op,
  input  fadd_pkg::rmode_e rmode,
  input  logic [`FP_W-1:0] a,
  input  logic [`FP_W-1:0] b,
  bypass_if.src            byp
);
  import fadd_pkg::*;

  logic [`EXP_W-1:0] exp_a;
  logic [`EXP_W-1:0] exp_b;
  logic              nan_a;
  logic              nan_b;
  logic              inf_a;
  logic              inf_b;
  logic              zero_a;
  logic              zero_b;
  logic              sign_a;
  logic              sign_b;
  logic              is_logic;
  logic              bad_inf;
  logic              hit;
  logic              invalid;
  logic              zero_sum;
  logic [`FP_W-1:0]  logic_res;
  logic [`FP_W-1:0]  value;

  assign exp_a  = a[`FP_W-2 -: `EXP_W];
  assign exp_b  = b[`FP_W-2 -: `EXP_W];
  assign inf_a  = (exp_a == `EXP_MAX) && (a[`FRAC_W-1:0] == '0);
  assign inf_b  = (exp_b == `EXP_MAX) && (b[`FRAC_W-1:0] == '0);
  assign nan_a  = (exp_a == `EXP_MAX) && (a[`FRAC_W-1:0] != '0);
  assign nan_b  = (exp_b == `EXP_MAX) && (b[`FRAC_W-1:0] != '0);
  // subnormals count as zero
  assign zero_a = (exp_a == '0);
  assign zero_b = (exp_b == '0);

  assign sign_a   = a[`FP_W-1];
  assign sign_b   = b[`FP_W-1] ^ (op == OP_SUB);
  assign is_logic = op inside {OP_AND, OP_OR, OP_XOR, OP_ANDN};
  assign bad_inf  = inf_a & inf_b & (sign_a ^ sign_b);

  always_comb begin
    case (op)
      OP_AND:  logic_res = a & b;
      OP_OR:   logic_res = a | b;
      OP_XOR:  logic_res = a ^ b;
      default: logic_res = a & ~b;
    endcase
  end

  always_comb begin
    hit      = 1'b1;
    invalid  = 1'b0;
    zero_sum = 1'b0;
    value    = logic_res;
    if (is_logic) begin
      value = logic_res;
    end else if (nan_a | nan_b | bad_inf) begin
      value   = `QNAN;
      invalid = 1'b1;
    end else if (inf_a) begin
      value = {sign_a, `EXP_MAX, {`FRAC_W{1'b0}}};
    end else if (inf_b) begin
      value = {sign_b, `EXP_MAX, {`FRAC_W{1'b0}}};
    end else if (zero_a & zero_b) begin
      // mixed-sign zeros are +0 here, round stage sets the sign for RND_MINUS
      value    = {sign_a & sign_b, {(`FP_W-1){1'b0}}};
      zero_sum = (sign_a ^ sign_b) & (rmode == RND_MINUS);
    end else if (zero_b) begin
      value = a;
    end else if (zero_a) begin
      value = {sign_b, b[`FP_W-2:0]};
    end else begin
      hit = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      byp.byp_hit      <= 1'b0;
      byp.byp_invalid  <= 1'b0;
      byp.byp_zero_sum <= 1'b0;
    end else begin
      byp.byp_hit      <= en & hit;
      byp.byp_invalid  <= en & invalid;
      byp.byp_zero_sum <= en & zero_sum;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      byp.byp_value <= value;
    end
  end

  // undefined opcodes would fall through to the adder
  assert property (@(posedge clk) disable iff (rst)
    en |-> op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ANDN});

endmodule

// ==== design/fadd_align.sv ====
`timescale 1ns/1ps
`include "fadd_defs.svh"

module fadd_align (
  input  logic             clk,
  input  logic             rst,
  input  logic             en,
  input  fadd_pkg::op_e    op,
  input  fadd_pkg::rmode_e rmode,
  input  logic [`FP_W-1:0] a,
  input  logic [`FP_W-1:0] b,
  align_if.src             s1
);
  import fadd_pkg::*;

  // beyond this shift only sticky survives
  localparam int SHIFT_CAP = `MANT_W + 2;

  logic [`EXP_W-1:0]            exp_a;
  logic [`EXP_W-1:0]            exp_b;
  logic [`MANT_W-1:0]           mant_a;
  logic [`MANT_W-1:0]           mant_b;
  logic                         sign_a;
  logic                         sign_b;
  logic                         sub;
  logic [`EXP_W:0]              diff_ab;
  logic [`EXP_W:0]              diff_ba;
  logic                         exp_eq;
  logic                         a_big;
  logic [`EXP_W-1:0]            shift;
  logic [`MANT_W-1:0]           big;
  logic [`MANT_W-1:0]           small_raw;
  logic [`MANT_W-1:0]           small_al;
  logic [`MANT_W+SHIFT_CAP-1:0] ext;

  assign exp_a  = a[`FP_W-2 -: `EXP_W];
  assign exp_b  = b[`FP_W-2 -: `EXP_W];
  // hidden one only for normal operands
  assign mant_a = (exp_a != '0) ? {1'b1, a[`FRAC_W-1:0], 3'b000} : '0;
  assign mant_b = (exp_b != '0) ? {1'b1, b[`FRAC_W-1:0], 3'b000} : '0;

  assign sign_a = a[`FP_W-1];
  assign sign_b = b[`FP_W-1] ^ (op == OP_SUB);
  assign sub    = sign_a ^ sign_b;

  // exponent difference both ways, borrow of a-b picks the larger
  assign diff_ab = {1'b0, exp_a} - {1'b0, exp_b};
  assign diff_ba = {1'b0, exp_b} - {1'b0, exp_a};
  assign exp_eq  = (diff_ab == '0);

  // equal exponents under subtract compare mantissas
  assign a_big = exp_eq ? (~sub | (mant_a >= mant_b)) : ~diff_ab[`EXP_W];

  assign shift     = a_big ? diff_ab[`EXP_W-1:0] : diff_ba[`EXP_W-1:0];
  assign big       = a_big ? mant_a : mant_b;
  assign small_raw = a_big ? mant_b : mant_a;

  assign ext = {small_raw, {SHIFT_CAP{1'b0}}} >> shift;

  always_comb begin
    if (shift >= SHIFT_CAP) begin
      small_al = {{(`MANT_W-1){1'b0}}, |small_raw};
    end else begin
      // bits shifted past guard and round fold into sticky
      small_al = {ext[`MANT_W+SHIFT_CAP-1:SHIFT_CAP+1],
                  ext[SHIFT_CAP] | (|ext[SHIFT_CAP-1:0])};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1.s1_valid <= 1'b0;
    end else begin
      s1.s1_valid <= en;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      s1.s1_sign  <= a_big ? sign_a : sign_b;
      s1.s1_exp   <= a_big ? exp_a : exp_b;
      s1.s1_big   <= big;
      s1.s1_small <= small_al;
      s1.s1_sub   <= sub;
      s1.s1_rmode <= rmode;
    end
  end

  // stage 2 subtracts without a sign fix-up
  assert property (@(posedge clk) disable iff (rst)
    s1.s1_valid && s1.s1_sub |-> s1.s1_big >= s1.s1_small);

endmodule

// ==== design/fadd_normalize.sv ====
`timescale 1ns/1ps
`include "fadd_defs.svh"

module fadd_normalize (
  input  logic [`MANT_W-1:0] mant_in,
  input  logic [`EXP_W-1:0]  exp_in,
  output logic [`MANT_W-1:0] mant_out,
  output logic [`EXP_W:0]    exp_out
);
  localparam int GROUPS = `MANT_W / 8;

  logic [2:0] grp;
  logic       grp_found;
  logic [7:0] grp_bits;
  logic [2:0] bit_pos;
  logic       bit_found;
  logic [5:0] lead_zeros;

  // first nonzero byte from the top
  always_comb begin
    grp       = '0;
    grp_found = 1'b0;
    for (int i = 0; i < GROUPS; i++) begin
      if (!grp_found && (mant_in[`MANT_W-1-8*i -: 8] != 8'h00)) begin
        grp       = 3'(i);
        grp_found = 1'b1;
      end
    end
  end

  assign grp_bits = mant_in[`MANT_W-1-8*grp -: 8];

  // then the leading bit inside it
  always_comb begin
    bit_pos   = '0;
    bit_found = 1'b0;
    for (int j = 0; j < 8; j++) begin
      if (!bit_found && grp_bits[7-j]) begin
        bit_pos   = 3'(j);
        bit_found = 1'b1;
      end
    end
  end

  assign lead_zeros = {grp, bit_pos};
  assign mant_out   = mant_in << lead_zeros;
  // may go to zero or below, round stage flushes that
  assign exp_out    = {1'b0, exp_in} - {6'b000000, lead_zeros};

endmodule

// ==== design/fadd_round.sv ====
`timescale 1ns/1ps
`include "fadd_defs.svh"

module fadd_round (
  input  logic             clk,
  input  logic             rst,
  align_if.dst             s1,
  bypass_if.dst            byp,
  output logic             res_valid,
  output logic [`FP_W-1:0] res,
  output logic             flag_invalid,
  output logic             flag_overflow,
  output logic             flag_underflow,
  output logic             flag_inexact
);
  import fadd_pkg::*;

  logic [`MANT_W:0]         sum;
  logic                     carry;
  logic [`MANT_W-1:0]       mant_n;
  logic [`EXP_W:0]          exp_n;
  logic [`MANT_W-1:0]       mant;
  logic signed [`EXP_W:0]   exp_s;
  logic                     lsb;
  logic                     grd;
  logic                     rnd;
  logic                     stk;
  logic                     inexact;
  logic                     round_up;
  logic                     to_inf;
  logic [`FRAC_W+1:0]       rounded;
  logic signed [`EXP_W+1:0] exp_r;
  logic [`FP_W-1:0]         arith_res;
  logic                     arith_ovf;
  logic                     arith_unf;
  logic                     arith_inx;

  assign sum = s1.s1_sub ? ({1'b0, s1.s1_big} - {1'b0, s1.s1_small})
                         : ({1'b0, s1.s1_big} + {1'b0, s1.s1_small});
  assign carry = sum[`MANT_W];

  fadd_normalize norm_i (
    .mant_in  (sum[`MANT_W-1:0]),
    .exp_in   (s1.s1_exp),
    .mant_out (mant_n),
    .exp_out  (exp_n)
  );

  // carry out: shift right once, dropped bit joins sticky
  assign mant  = carry ? {sum[`MANT_W:2], sum[1] | sum[0]} : mant_n;
  assign exp_s = carry ? $signed({1'b0, s1.s1_exp} + 12'd1) : $signed(exp_n);

  assign lsb     = mant[3];
  assign grd     = mant[2];
  assign rnd     = mant[1];
  assign stk     = mant[0];
  assign inexact = grd | rnd | stk;

  always_comb begin
    case (s1.s1_rmode)
      RND_EVEN:  round_up = grd & (rnd | stk | lsb);
      RND_PLUS:  round_up = inexact & ~s1.s1_sign;
      RND_MINUS: round_up = inexact & s1.s1_sign;
      default:   round_up = 1'b0;
    endcase
  end

  // overflow saturates unless the mode points away from zero
  assign to_inf = (s1.s1_rmode == RND_EVEN) ||
                  ((s1.s1_rmode == RND_PLUS) && !s1.s1_sign) ||
                  ((s1.s1_rmode == RND_MINUS) && s1.s1_sign);

  assign rounded = {1'b0, mant[`MANT_W-1:3]} + {{(`FRAC_W+1){1'b0}}, round_up};
  assign exp_r   = {exp_s[`EXP_W], exp_s} + {{(`EXP_W+1){1'b0}}, rounded[`FRAC_W+1]};

  always_comb begin
    arith_ovf = 1'b0;
    arith_unf = 1'b0;
    arith_inx = inexact;
    arith_res = {s1.s1_sign, exp_r[`EXP_W-1:0], rounded[`FRAC_W-1:0]};
    if (sum == '0) begin
      // exact cancellation
      arith_res = {s1.s1_rmode == RND_MINUS, {(`FP_W-1){1'b0}}};
      arith_inx = 1'b0;
    end else if (exp_s < 1) begin
      arith_res = {s1.s1_sign, {(`FP_W-1){1'b0}}};
      arith_unf = 1'b1;
      arith_inx = 1'b1;
    end else if (exp_r >= $signed({2'b00, `EXP_MAX})) begin
      arith_ovf = 1'b1;
      arith_inx = 1'b1;
      arith_res = to_inf ? {s1.s1_sign, `EXP_MAX, {`FRAC_W{1'b0}}}
                         : {s1.s1_sign, `MAXFIN_EXP, {`FRAC_W{1'b1}}};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid      <= 1'b0;
      res            <= '0;
      flag_invalid   <= 1'b0;
      flag_overflow  <= 1'b0;
      flag_underflow <= 1'b0;
      flag_inexact   <= 1'b0;
    end else begin
      res_valid <= s1.s1_valid;
      if (s1.s1_valid && byp.byp_hit) begin
        res            <= {byp.byp_value[`FP_W-1] | byp.byp_zero_sum,
                           byp.byp_value[`FP_W-2:0]};
        flag_invalid   <= byp.byp_invalid;
        flag_overflow  <= 1'b0;
        flag_underflow <= 1'b0;
        flag_inexact   <= 1'b0;
      end else if (s1.s1_valid) begin
        res            <= arith_res;
        flag_invalid   <= 1'b0;
        flag_overflow  <= arith_ovf;
        flag_underflow <= arith_unf;
        flag_inexact   <= arith_inx;
      end else begin
        flag_invalid   <= 1'b0;
        flag_overflow  <= 1'b0;
        flag_underflow <= 1'b0;
        flag_inexact   <= 1'b0;
      end
    end
  end

  // no result leaks out of the flushed pipeline
  assert property (@(posedge clk) $fell(rst) |=> !res_valid);

endmodule

// ==== design/fadd_top.sv ====
`timescale 1ns/1ps
`include "fadd_defs.svh"

module fadd_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             en,
  input  fadd_pkg::op_e    op,
  input  fadd_pkg::rmode_e rmode,
  input  logic [`FP_W-1:0] a,
  input  logic [`FP_W-1:0] b,
  output logic             res_valid,
  output logic [`FP_W-1:0] res,
  output logic             flag_invalid,
  output logic             flag_overflow,
  output logic             flag_underflow,
  output logic             flag_inexact
);

  align_if  s1_bus ();
  bypass_if byp_bus ();

  // special operands and logic ops
  fadd_bypass bypass_i (
    .clk   (clk),
    .rst   (rst),
    .en    (en),
    .op    (op),
    .rmode (rmode),
    .a     (a),
    .b     (b),
    .byp   (byp_bus.src)
  );

  // stage 1
  fadd_align align_i (
    .clk   (clk),
    .rst   (rst),
    .en    (en),
    .op    (op),
    .rmode (rmode),
    .a     (a),
    .b     (b),
    .s1    (s1_bus.src)
  );

  // stage 2
  fadd_round round_i (
    .clk            (clk),
    .rst            (rst),
    .s1             (s1_bus.dst),
    .byp            (byp_bus.dst),
    .res_valid      (res_valid),
    .res            (res),
    .flag_invalid   (flag_invalid),
    .flag_overflow  (flag_overflow),
    .flag_underflow (flag_underflow),
    .flag_inexact   (flag_inexact)
  );

endmodule

// ==== verif/fadd_model.svh ====
`ifndef FADD_MODEL_SVH
`define FADD_MODEL_SVH

// model results pack as {invalid, overflow, underflow, inexact, value}

// right shift, every bit shifted out ORs into the lsb
function automatic logic [55:0] shift_sticky(logic [55:0] m, int unsigned sh);
  logic [55:0] lost_mask;
  if (sh >= 56) begin
    return {55'd0, |m};
  end
  lost_mask = (56'd1 << sh) - 56'd1;
  return (m >> sh) | {55'd0, |(m & lost_mask)};
endfunction

function automatic int count_lead(logic [55:0] m);
  int n;
  bit found;
  n = 0;
  found = 1'b0;
  for (int i = 55; i >= 0; i--) begin
    if (m[i]) begin
      found = 1'b1;
    end else if (!found) begin
      n++;
    end
  end
  return n;
endfunction

// both operands normal and finite
function automatic logic [67:0] arith_result(logic sa, logic sb, logic [10:0] ea,
                                             logic [10:0] eb, logic [55:0] ma,
                                             logic [55:0] mb, rmode_e rm);
  logic        a_first;
  logic        sign;
  logic [55:0] big;
  logic [55:0] lesser;
  logic [56:0] sum;
  logic [55:0] m;
  logic        inx;
  logic        up;
  logic        away;
  logic [53:0] r;
  int          e;
  a_first = (ea > eb) || (ea == eb && (sa == sb || ma >= mb));
  sign    = a_first ? sa : sb;
  e       = a_first ? ea : eb;
  big     = a_first ? ma : mb;
  lesser  = shift_sticky(a_first ? mb : ma, a_first ? ea - eb : eb - ea);
  sum     = (sa != sb) ? big - lesser : big + lesser;
  if (sum == '0) begin
    return {4'b0000, rm == RND_MINUS, 63'd0};
  end
  if (sum[56]) begin
    m = {sum[56:2], sum[1] | sum[0]};
    e = e + 1;
  end else begin
    m = sum[55:0] << count_lead(sum[55:0]);
    e = e - count_lead(sum[55:0]);
  end
  // flush to zero below the smallest normal exponent
  if (e < 1) begin
    return {4'b0011, sign, 63'd0};
  end
  inx = |m[2:0];
  case (rm)
    RND_EVEN:  up = m[2] & (m[1] | m[0] | m[3]);
    RND_PLUS:  up = inx & ~sign;
    RND_MINUS: up = inx & sign;
    default:   up = 1'b0;
  endcase
  r = {1'b0, m[55:3]} + {53'd0, up};
  if (r[53]) begin
    e = e + 1;
  end
  if (e >= 2047) begin
    away = (rm == RND_EVEN) || (rm == RND_PLUS && !sign) || (rm == RND_MINUS && sign);
    return away ? {4'b0101, sign, 11'h7FF, 52'd0} : {4'b0101, sign, 11'h7FE, {52{1'b1}}};
  end
  return {3'b000, inx, sign, e[10:0], r[51:0]};
endfunction

function automatic logic [67:0] expected_result(op_e o, rmode_e rm, logic [63:0] a,
                                                logic [63:0] b);
  logic        sa;
  logic        sb;
  logic [10:0] ea;
  logic [10:0] eb;
  sa = a[63];
  sb = b[63] ^ (o == OP_SUB);
  ea = a[62:52];
  eb = b[62:52];
  case (o)
    OP_AND:  return {4'b0000, a & b};
    OP_OR:   return {4'b0000, a | b};
    OP_XOR:  return {4'b0000, a ^ b};
    OP_ANDN: return {4'b0000, a & ~b};
    default: ;
  endcase
  if ((ea == 11'h7FF && a[51:0] != '0) || (eb == 11'h7FF && b[51:0] != '0)) begin
    return {4'b1000, `QNAN};
  end
  if (ea == 11'h7FF && eb == 11'h7FF && sa != sb) begin
    return {4'b1000, `QNAN};
  end
  if (ea == 11'h7FF) begin
    return {4'b0000, sa, 11'h7FF, 52'd0};
  end
  if (eb == 11'h7FF) begin
    return {4'b0000, sb, 11'h7FF, 52'd0};
  end
  // exponent 0 reads as signed zero
  if (ea == '0 && eb == '0) begin
    return {4'b0000, (sa & sb) | ((sa ^ sb) & (rm == RND_MINUS)), 63'd0};
  end
  if (eb == '0) begin
    return {4'b0000, a};
  end
  if (ea == '0) begin
    return {4'b0000, sb, b[62:0]};
  end
  return arith_result(sa, sb, ea, eb, {1'b1, a[51:0], 3'b000}, {1'b1, b[51:0], 3'b000}, rm);
endfunction

`endif

// ==== verif/fadd_tb.sv ====
`timescale 1ns/1ps
`include "fadd_defs.svh"

module fadd_tb;
  import fadd_pkg::*;

  `include "fadd_model.svh"

  localparam int N_RAND    = 400;
  localparam int N_CANCEL  = 200;
  localparam int N_SPECIAL = 150;
  localparam int N_RANGE   = 150;
  localparam int N_LOGIC   = 200;
  localparam int N_TOTAL   = N_RAND + N_CANCEL + N_SPECIAL + N_RANGE + N_LOGIC;
  localparam int MAX_GAP   = 2;

  logic        clk;
  logic        rst;
  logic        en;
  op_e         op;
  rmode_e      rmode;
  logic [63:0] a;
  logic [63:0] b;
  logic        res_valid;
  logic [63:0] res;
  logic        flag_invalid;
  logic        flag_overflow;
  logic        flag_underflow;
  logic        flag_inexact;

  integer      seed;
  int          cycle = 0;
  int          errors = 0;
  int          checks = 0;
  int          mark;
  logic [67:0] expect_q[$];
  int          due_q[$];

  fadd_top fadd_top_i (
    .clk            (clk),
    .rst            (rst),
    .en             (en),
    .op             (op),
    .rmode          (rmode),
    .a              (a),
    .b              (b),
    .res_valid      (res_valid),
    .res            (res),
    .flag_invalid   (flag_invalid),
    .flag_overflow  (flag_overflow),
    .flag_underflow (flag_underflow),
    .flag_inexact   (flag_inexact)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want);
    end
  endtask

  task automatic check_output();
    logic [67:0] exp_v;
    int          due;
    if (res_valid) begin
      if (expect_q.size() == 0) begin
        errors++;
        $display("%0t: res_valid high with no operation in flight", $time);
      end else begin
        exp_v = expect_q.pop_front();
        due   = due_q.pop_front();
        if (due != cycle) begin
          errors++;
          $display("%0t: result came at cycle %0d, due at cycle %0d", $time, cycle, due);
        end
        compare_value("res", res, exp_v[63:0]);
        compare_value("flag_invalid", flag_invalid, exp_v[67]);
        compare_value("flag_overflow", flag_overflow, exp_v[66]);
        compare_value("flag_underflow", flag_underflow, exp_v[65]);
        compare_value("flag_inexact", flag_inexact, exp_v[64]);
      end
    end else if (expect_q.size() != 0 && due_q[0] <= cycle) begin
      errors++;
      $display("%0t: no res_valid %0d cycles after en", $time, `FADD_LAT);
      exp_v = expect_q.pop_front();
      due   = due_q.pop_front();
    end
  endtask

  // outputs are settled by the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      if (en) begin
        expect_q.push_back(expected_result(op, rmode, a, b));
        due_q.push_back(cycle + `FADD_LAT);
      end
      check_output();
    end
  end

  task automatic rand_word(output logic [63:0] w);
    w = {$random(seed), $random(seed)};
  endtask

  task automatic pick_special(output logic [63:0] w);
    logic [31:0] r;
    r = $random(seed);
    rand_word(w);
    case ($unsigned(r) % 6)
      0: begin
        w[62:52] = 11'h7FF;
        w[0]     = 1'b1;
      end
      1: w[62:0] = {11'h7FF, 52'd0};
      2: w[62:0] = '0;
      // subnormal
      3: w[62:52] = '0;
      default: w[62:52] = 11'd1000 + 11'(r[12:8]);
    endcase
  endtask

  task automatic make_operands(input int kind, output op_e o, output logic [63:0] x,
                               output logic [63:0] y);
    logic [63:0] t;
    logic [31:0] r;
    logic [10:0] ea;
    r  = $random(seed);
    o  = r[4] ? OP_SUB : OP_ADD;
    ea = 11'd960 + 11'(r[31:25]);
    rand_word(x);
    rand_word(y);
    rand_word(t);
    case (kind)
      0: begin
        // mostly nearby exponents, a few across the whole range
        x[62:52] = (r[3:0] == 4'd0) ? 11'(1 + r[31:21] % 2046) : ea;
        y[62:52] = ea + 11'(r[12:6] % 121) - 11'd60;
      end
      1: begin
        ea       = 11'd16 + 11'(r[31:21] % 2000);
        x[62:52] = ea;
        y        = x;
        y[51:0]  = x[51:0] ^ (t[51:0] >> r[10:5]);
        y[62:52] = ea - 11'(r[12:11]);
        // effective subtract
        y[63]    = x[63] ^ (o == OP_ADD);
      end
      2: begin
        pick_special(x);
        pick_special(y);
      end
      3: begin
        if (r[5]) begin
          x[62:52] = 11'd2045 + 11'(r[6]);
          y[62:52] = 11'd2045 + 11'(r[7]);
          y[63]    = x[63] ^ (o == OP_SUB);
        end else begin
          // tiny operands cancelling below exponent 1
          x[62:52] = 11'd1 + 11'(r[7:6] % 3);
          y[62:52] = 11'd1 + 11'(r[8]);
          y[63]    = x[63] ^ (o == OP_ADD);
        end
      end
      default: begin
        o        = op_e'($unsigned(r) % 6);
        x[62:52] = ea;
        y[62:52] = ea - 11'(r[3:0]);
      end
    endcase
  endtask

  task automatic drive_op(input op_e o, input rmode_e rm, input logic [63:0] x,
                          input logic [63:0] y, input int max_gap);
    int gap;
    @(posedge clk);
    en    <= 1'b1;
    op    <= o;
    rmode <= rm;
    a     <= x;
    b     <= y;
    gap = $unsigned($random(seed)) % (max_gap + 1);
    repeat (gap) begin
      @(posedge clk);
      en <= 1'b0;
    end
  endtask

  task automatic run_test(input string name, input int kind, input int n, input int max_gap);
    op_e         o;
    logic [63:0] x;
    logic [63:0] y;
    logic [31:0] r;
    int          start_errors;
    start_errors = errors;
    for (int i = 0; i < n; i++) begin
      make_operands(kind, o, x, y);
      r = $random(seed);
      drive_op(o, rmode_e'(r[1:0]), x, y, max_gap);
    end
    @(posedge clk);
    en <= 1'b0;
    while (expect_q.size() != 0) begin
      @(posedge clk);
    end
    $display("test %s: %0d operations, %0d errors", name, n, errors - start_errors);
  endtask

  // each operation takes at most MAX_GAP + 1 cycles
  initial begin
    #((N_TOTAL * (MAX_GAP + 1) + 200) * 40);
    $display("timeout: run did not finish, %0d results still pending", expect_q.size());
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    seed  = 40858;
    rst   = 1'b1;
    en    = 1'b0;
    op    = OP_ADD;
    rmode = RND_EVEN;
    a     = '0;
    b     = '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    mark = errors;
    repeat (5) begin
      @(negedge clk);
      compare_value("res_valid", res_valid, 64'd0);
      compare_value("res", res, 64'd0);
      compare_value("flag_invalid", flag_invalid, 64'd0);
      compare_value("flag_overflow", flag_overflow, 64'd0);
      compare_value("flag_underflow", flag_underflow, 64'd0);
      compare_value("flag_inexact", flag_inexact, 64'd0);
    end
    $display("test idle after reset: 0 operations, %0d errors", errors - mark);

    run_test("random add and subtract", 0, N_RAND, MAX_GAP);
    run_test("cancellation", 1, N_CANCEL, MAX_GAP);
    run_test("special operands", 2, N_SPECIAL, MAX_GAP);
    run_test("overflow and underflow", 3, N_RANGE, MAX_GAP);
    run_test("logic ops back to back", 4, N_LOGIC, 0);

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+design
+incdir+verif
design/fadd_pkg.sv
design/fadd_if.sv
design/fadd_bypass.sv
design/fadd_align.sv
design/fadd_normalize.sv
design/fadd_round.sv
design/fadd_top.sv
verif/fadd_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module fadd_tb \
  -o fadd_sim > build.log 2>&1 &&
  ./obj_dir/fadd_sim > sim.log 2>&1 ||
  { echo "build or simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log && echo "simulation passed" ||
  { echo "simulation failed, see sim.log"; exit 1; }
